//--- src.f
+incdir+design
design/routerPkg.sv
design/inputPort.sv
design/outputArbiter.sv
design/outputPort.sv
design/meshRouter.sv
sim/routerTb.sv

//--- Bender.yml
package:
  name: mesh_router

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/routerPkg.sv
      - design/inputPort.sv
      - design/outputArbiter.sv
      - design/outputPort.sv
      - design/meshRouter.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/routerTb.sv

//--- sim/routerTb.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module routerTb;
  import routerPkg::*;

  localparam int selfX = 2;
  localparam int selfY = 2;
  localparam int pw    = `PAYLOAD_WIDTH;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  flitT [4:0] inFlit;
  logic [4:0] inValid;
  logic [4:0] creditIn;
  logic [4:0] creditOut;
  flitT [4:0] outFlit;
  logic [4:0] outValid;

  flitT       sendQ [5][$];
  flitT       expQ [25][$];   // Index is output*5 + source
  int         retQ [5][$];    // Cycle at which a downstream credit goes back
  int         headLog [5][$];
  int         upCredit [5];
  int         accepted [5];
  int         returned [5];
  int         rxFlits [5];
  int         curSrc [5];
  int         remaining [5];
  logic [4:0] withhold;
  int         maxDelay;
  int         cycle;
  int         seed;
  int         seqNum;
  int         errors;
  int         checks;
  int         tests;
  bit         hung;

  meshRouter #(
    .routerX(selfX),
    .routerY(selfY)
  ) u_meshRouter (
    .clk      (clk),
    .rst      (rst),
    .inFlit   (inFlit),
    .inValid  (inValid),
    .creditIn (creditIn),
    .creditOut(creditOut),
    .outFlit  (outFlit),
    .outValid (outValid)
  );

  always #5 clk = ~clk;

  // XY routing as seen from this router
  function automatic portSel expectedPort(input int dx, input int dy);
    if (dx > selfX)
      return portEast;
    if (dx < selfX)
      return portWest;
    if (dy > selfY)
      return portNorth;
    if (dy < selfY)
      return portSouth;
    return portLocal;
  endfunction

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Top 12 payload bits carry source and sequence number
  task automatic sendPacket(input int src, input int dx, input int dy, input int len);
    headFields hf;
    flitT      f;
    int        dest;
    int        k;
    dest      = int'(expectedPort(dx, dy));
    hf.destX  = `COORD_WIDTH'(dx);
    hf.destY  = `COORD_WIDTH'(dy);
    hf.length = `LEN_WIDTH'(len);
    for (k = 0; k < len; k++)
    begin
      f.kind    = (k == 0) ? flitHead : flitBody;
      f.payload = $random(seed);
      if (k == 0)
        f.payload[$bits(headFields)-1:0] = hf;
      f.payload[pw-1 -: 12] = {3'(src), 9'(seqNum)};
      sendQ[src].push_back(f);
      expQ[dest*5 + src].push_back(f);
    end
    seqNum++;
  endtask

  // Upstream side: one flit per input per cycle while credit lasts
  always @(negedge clk)
  begin
    for (int i = 0; i < 5; i++)
    begin
      if (creditOut[i])
      begin
        upCredit[i]++;
        returned[i]++;
      end
      inValid[i] = 1'b0;
      if (!rst && upCredit[i] > 0 && sendQ[i].size() > 0)
      begin
        inFlit[i]  = sendQ[i].pop_front();
        inValid[i] = 1'b1;
        upCredit[i]--;
        accepted[i]++;
      end
    end
  end

  task automatic checkFlit(input int o, input flitT got);
    headFields hf;
    int        src;
    int        idx;
    checks++;
    if (remaining[o] > 0)
      src = curSrc[o];
    else
    begin
      src = int'(got.payload[pw-1 -: 3]);
      if (got.kind != flitHead || src > 4)
      begin
        $display("[ERROR] %0t: output %0d got %h outside any packet", $time, o, got);
        errors++;
        return;
      end
      hf           = headFields'(got.payload[$bits(headFields)-1:0]);
      remaining[o] = int'(hf.length);
      curSrc[o]    = src;
      headLog[o].push_back(src);
    end
    idx = o*5 + src;
    remaining[o]--;
    if (expQ[idx].size() == 0)
    begin
      $display("[ERROR] %0t: output %0d got %h from input %0d, none expected", $time, o,
               got, src);
      errors++;
    end
    else
    begin
      if (got !== expQ[idx][0])
      begin
        $display("[ERROR] %0t: output %0d got %h, expected %h", $time, o, got, expQ[idx][0]);
        errors++;
      end
      void'(expQ[idx].pop_front());
    end
  endtask

  // Downstream side and compare process
  always @(negedge clk)
  begin
    int delay;
    cycle++;
    for (int o = 0; o < 5; o++)
    begin
      creditIn[o] = 1'b0;
      if (!withhold[o] && retQ[o].size() > 0 && retQ[o][0] <= cycle)
      begin
        void'(retQ[o].pop_front());
        creditIn[o] = 1'b1;
      end
      if (outValid[o])
      begin
        rxFlits[o]++;
        delay = (maxDelay > 0) ? randBelow(maxDelay + 1) : 0;
        retQ[o].push_back(cycle + 1 + delay);
        checkFlit(o, outFlit[o]);
      end
    end
  end

  function automatic bit drained();
    for (int i = 0; i < 5; i++)
    begin
      if (sendQ[i].size() > 0 || retQ[i].size() > 0 || remaining[i] > 0)
        return 1'b0;
      if (upCredit[i] < `BUFFER_DEPTH)
        return 1'b0;
    end
    for (int i = 0; i < 25; i++)
    begin
      if (expQ[i].size() > 0)
        return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic waitDrain(input string what);
    int n;
    n = 0;
    while (!drained() && n < 5000)
    begin
      @(posedge clk);
      n++;
    end
    if (!drained())
    begin
      $display("Timeout: %0s still in flight after 5000 cycles", what);
      hung = 1'b1;
    end
  endtask

  task automatic waitFlits(input int o, input int target, input string what);
    int n;
    n = 0;
    while (rxFlits[o] < target && n < 500)
    begin
      @(posedge clk);
      n++;
    end
    if (rxFlits[o] < target)
    begin
      $display("Timeout: %0s never reached output %0d", what, o);
      hung = 1'b1;
    end
  endtask

  task automatic checkOrder(input int o, input int order[$]);
    bit same;
    checks++;
    same = (headLog[o].size() == order.size());
    for (int k = 0; k < order.size() && same; k++)
    begin
      if (headLog[o][k] != order[k])
        same = 1'b0;
    end
    if (!same)
    begin
      $display("[ERROR] %0t: output %0d sent packets from inputs %p, expected %p", $time, o,
               headLog[o], order);
      errors++;
    end
  endtask

  task automatic clearLogs();
    for (int o = 0; o < 5; o++)
      headLog[o].delete();
  endtask

  task automatic endTest(input string name, input int startErrors);
    tests++;
    $display("%0s finished with %0d errors", name, errors - startErrors);
  endtask

  task automatic testRouting();
    int e0;
    e0 = errors;
    clearLogs();
    sendPacket(0, 4, 2, 3);   // East
    sendPacket(0, 0, 2, 2);   // West
    sendPacket(0, 2, 3, 1);   // North
    sendPacket(0, 2, 0, 4);   // South
    sendPacket(0, 2, 2, 2);   // Back out on local
    waitDrain("routing packets");
    for (int o = 0; o < 5; o++)
    begin
      checks++;
      if (headLog[o].size() != 1)
      begin
        $display("[ERROR] %0t: output %0d carried %0d packets, expected 1", $time, o,
                 headLog[o].size());
        errors++;
      end
    end
    endTest("routing", e0);
  endtask

  task automatic testWormhole();
    int e0;
    int order[$];
    e0 = errors;
    clearLogs();
    sendPacket(1, 3, 2, 5);
    sendPacket(3, 4, 3, 5);
    waitDrain("competing packets");
    order = {1, 3};
    checkOrder(2, order);
    endTest("wormhole hold", e0);
  endtask

  task automatic testRotation();
    int e0;
    int base;
    int order[$];
    e0 = errors;
    clearLogs();
    for (int s = 0; s < 5; s++)
      sendPacket(s, 3, 2, 2);
    waitDrain("first rotation round");
    order = {0, 1, 2, 3, 4};
    checkOrder(2, order);
    clearLogs();
    base = rxFlits[2];
    sendPacket(1, 4, 2, 6);   // North takes the idle output first
    waitFlits(2, base + 1, "north head");
    sendPacket(0, 3, 2, 2);
    sendPacket(2, 3, 2, 2);
    sendPacket(3, 3, 2, 2);
    sendPacket(4, 3, 2, 2);
    waitDrain("second rotation round");
    order = {1, 2, 3, 4, 0};
    checkOrder(2, order);
    endTest("rotation", e0);
  endtask

  task automatic testBackPressure();
    int e0;
    int base;
    e0 = errors;
    withhold[2] = 1'b1;
    base = rxFlits[2];
    sendPacket(0, 4, 2, 8);
    waitFlits(2, base + `BUFFER_DEPTH, "flits ahead of the stall");
    repeat (20) @(posedge clk);   // East must stay silent without credit
    checks++;
    if (rxFlits[2] != base + `BUFFER_DEPTH)
    begin
      $display("[ERROR] %0t: %0d flits left east with no credit", $time,
               rxFlits[2] - base - `BUFFER_DEPTH);
      errors++;
    end
    withhold[2] = 1'b0;
    waitDrain("stalled packet");
    checks++;
    if (rxFlits[2] != base + 8)
    begin
      $display("[ERROR] %0t: east delivered %0d flits, expected 8", $time, rxFlits[2] - base);
      errors++;
    end
    endTest("back-pressure", e0);
  endtask

  task automatic testRandom();
    int e0;
    e0 = errors;
    maxDelay = 7;
    for (int p = 0; p < 60; p++)
      sendPacket(randBelow(5), randBelow(5), randBelow(5), 1 + randBelow(6));
    waitDrain("random traffic");
    maxDelay = 0;
    endTest("random traffic", e0);
  endtask

  task automatic testCreditReturn();
    int e0;
    e0 = errors;
    for (int i = 0; i < 5; i++)
    begin
      checks++;
      if (returned[i] != accepted[i])
      begin
        $display("[ERROR] %0t: input %0d returned %0d credits for %0d flits", $time, i,
                 returned[i], accepted[i]);
        errors++;
      end
    end
    endTest("credit return", e0);
  endtask

  initial
  begin
    seed     = 86729;
    inFlit   = '0;
    inValid  = '0;
    creditIn = '0;
    withhold = '0;
    maxDelay = 0;
    foreach (upCredit[i])
      upCredit[i] = `BUFFER_DEPTH;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    if (!hung)
      testRouting();
    if (!hung)
      testWormhole();
    if (!hung)
      testRotation();
    if (!hung)
      testBackPressure();
    if (!hung)
      testRandom();
    if (!hung)
      testCreditReturn();
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0 && !hung)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- design/meshRouter.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module meshRouter #(
  parameter int routerX = 0,
  parameter int routerY = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::flitT [4:0] inFlit,
  input  logic [4:0]            inValid,
  input  logic [4:0]            creditIn,
  output logic [4:0]            creditOut,
  output routerPkg::flitT [4:0] outFlit,
  output logic [4:0]            outValid
);
  import routerPkg::*;

  wire flitT [4:0]                frontFlit;
  wire [4:0][4:0]                 reqByInput;    // [input][output]
  wire [4:0][4:0]                 reqByOutput;   // [output][input]
  wire [4:0][`LEN_WIDTH-1:0]      headLength;
  wire [4:0][4:0]                 grant;         // [output][input]
  wire [4:0][4:0]                 moveByInput;   // [input][output]
  wire [4:0]                      advance;
  wire [4:0]                      hasCredit;
  wire [4:0]                      pop;

  for (genvar i = 0; i < 5; i++)
  begin : genInput
    inputPort #(
      .routerX(routerX),
      .routerY(routerY)
    ) u_inputPort (
      .clk       (clk),
      .rst       (rst),
      .inFlit    (inFlit[i]),
      .inValid   (inValid[i]),
      .pop       (pop[i]),
      .frontFlit (frontFlit[i]),
      .request   (reqByInput[i]),
      .headLength(headLength[i]),
      .creditOut (creditOut[i])
    );

    // At most one output advances a given input
    assign pop[i] = |moveByInput[i];
  end

  for (genvar o = 0; o < 5; o++)
  begin : genOutput
    for (genvar i = 0; i < 5; i++)
    begin : genTranspose
      assign reqByOutput[o][i] = reqByInput[i][o];
      assign moveByInput[i][o] = grant[o][i] & advance[o];
    end

    outputArbiter u_outputArbiter (
      .clk       (clk),
      .rst       (rst),
      .request   (reqByOutput[o]),
      .headLength(headLength),
      .hasCredit (hasCredit[o]),
      .grant     (grant[o]),
      .advance   (advance[o])
    );

    outputPort u_outputPort (
      .clk       (clk),
      .rst       (rst),
      .frontFlits(frontFlit),
      .grant     (grant[o]),
      .advance   (advance[o]),
      .creditIn  (creditIn[o]),
      .hasCredit (hasCredit[o]),
      .outFlit   (outFlit[o]),
      .outValid  (outValid[o])
    );
  end

endmodule

//--- design/outputPort.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module outputPort (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::flitT [4:0] frontFlits,
  input  logic [4:0]            grant,
  input  logic                  advance,
  input  logic                  creditIn,
  output logic                  hasCredit,
  output routerPkg::flitT       outFlit,
  output logic                  outValid
);
  import routerPkg::*;

  localparam int creditWidth = $clog2(`BUFFER_DEPTH + 1);

  flitT                   selected;
  logic [creditWidth-1:0] credits;

  // Crossbar column for this output
  always_comb
  begin
    selected = '0;
    for (int i = 0; i < 5; i++)
    begin
      if (grant[i])
        selected = frontFlits[i];
    end
  end

  always_ff @(posedge clk)
  begin
    if (advance)
      outFlit <= selected;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= advance;
  end

  // Downstream FIFO slots still free
  always_ff @(posedge clk)
  begin
    if (rst)
      credits <= creditWidth'(`BUFFER_DEPTH);
    else
    begin
      case ({advance, creditIn})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;   // Both or neither
      endcase
    end
  end

  assign hasCredit = (credits != '0);

endmodule

//--- design/outputArbiter.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module outputArbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [4:0]                 request,
  input  logic [4:0][`LEN_WIDTH-1:0] headLength,
  input  logic                       hasCredit,
  output logic [4:0]                 grant,
  output logic                       advance
);
  import routerPkg::*;

  arbState                    state;
  arbState                    nextState;
  logic [4:0]                 active;
  logic [4:0]                 timesUp;
  logic [4:0][`LEN_WIDTH-1:0] holdLen;
  logic [4:0][`LEN_WIDTH-1:0] flitCount;
  logic                       hold;
  int                         curIdx;

  // First requester among span inputs, starting at index first
  function automatic arbState rotatePick(input logic [4:0] req, input int first,
                                         input int span);
    arbState pick;
    int      idx;
    pick = idle;
    for (int k = 4; k >= 0; k--)
    begin
      idx = (first + k) % 5;
      if (k < span && req[idx])
        pick = arbState'(idx + 1);
    end
    return pick;
  endfunction

  always_comb
  begin
    grant = '0;
    if (state != idle)
      grant[state - 3'd1] = 1'b1;
  end

  // Hold timers, one per input
  for (genvar i = 0; i < 5; i++)
  begin : genTimer
    always_ff @(posedge clk)
    begin
      if (grant[i] && advance && !active[i])
        holdLen[i] <= headLength[i];  // Head flit is at the front here
    end

    always_ff @(posedge clk)
    begin
      if (rst)
      begin
        active[i]    <= 1'b0;
        flitCount[i] <= '0;
      end
      else if (grant[i] && advance)
      begin
        active[i]    <= 1'b1;
        flitCount[i] <= active[i] ? flitCount[i] + 1'b1 : `LEN_WIDTH'(1);
      end
      else if (!grant[i])
      begin
        active[i]    <= 1'b0;
        flitCount[i] <= '0;
      end
    end

    assign timesUp[i] = active[i] && (flitCount[i] == holdLen[i]);
  end

  // A packet in flight keeps its output even while its FIFO runs dry
  assign hold    = |(grant & (request | active) & ~timesUp);
  assign advance = hasCredit && |(grant & request & ~timesUp);
  assign curIdx  = int'(state) - 1;

  always_comb
  begin
    nextState = state;
    if (state == idle)
      nextState = rotatePick(request, 0, 5);   // Local first, south last
    else if (!hold)
      nextState = rotatePick(request, curIdx + 1, 4);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= idle;
    else
      state <= nextState;
  end

endmodule

//--- design/inputPort.sv
`timescale 1ns/1ps
`include "router_settings.svh"

module inputPort #(
  parameter int routerX = 0,
  parameter int routerY = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  routerPkg::flitT       inFlit,
  input  logic                  inValid,
  input  logic                  pop,
  output routerPkg::flitT       frontFlit,
  output logic [4:0]            request,
  output logic [`LEN_WIDTH-1:0] headLength,
  output logic                  creditOut
);
  import routerPkg::*;

  localparam int ptrWidth  = (`BUFFER_DEPTH > 1) ? $clog2(`BUFFER_DEPTH) : 1;
  localparam int fillWidth = $clog2(`BUFFER_DEPTH + 1);
  localparam logic [`COORD_WIDTH-1:0] selfX = `COORD_WIDTH'(routerX);
  localparam logic [`COORD_WIDTH-1:0] selfY = `COORD_WIDTH'(routerY);

  flitT                 fifoMem [`BUFFER_DEPTH];
  logic [ptrWidth-1:0]  wrPtr;
  logic [ptrWidth-1:0]  rdPtr;
  logic [fillWidth-1:0] fill;
  logic                 fifoEmpty;
  headFields            frontHead;
  portSel               headRoute;
  portSel               routeReg;
  portSel               route;

  // Circular pointer step, depth need not be a power of two
  function automatic logic [ptrWidth-1:0] bump(input logic [ptrWidth-1:0] ptr);
    return (ptr == ptrWidth'(`BUFFER_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk)
  begin
    if (inValid)
      fifoMem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end
    else
    begin
      if (inValid)
        wrPtr <= bump(wrPtr);
      if (pop)
        rdPtr <= bump(rdPtr);
      case ({inValid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  assign fifoEmpty = (fill == '0);
  assign frontFlit = fifoMem[rdPtr];
  assign frontHead = headFields'(frontFlit.payload[headWidth-1:0]);
  assign headLength = frontHead.length;

  // XY order, X resolved first
  always_comb
  begin
    if (frontHead.destX > selfX)
      headRoute = portEast;
    else if (frontHead.destX < selfX)
      headRoute = portWest;
    else if (frontHead.destY > selfY)
      headRoute = portNorth;
    else if (frontHead.destY < selfY)
      headRoute = portSouth;
    else
      headRoute = portLocal;
  end

  // Body flits reuse the route their head took
  always_ff @(posedge clk)
  begin
    if (rst)
      routeReg <= portLocal;
    else if (pop && frontFlit.kind == flitHead)
      routeReg <= headRoute;
  end

  assign route = (frontFlit.kind == flitHead) ? headRoute : routeReg;

  always_comb
  begin
    request = '0;
    if (!fifoEmpty)
      request[route] = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      creditOut <= 1'b0;
    else
      creditOut <= pop;   // One slot freed upstream
  end

endmodule

//--- design/routerPkg.sv
`include "router_settings.svh"

package routerPkg;

  // Doubles as request and grant bit index
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portSel;

  typedef enum logic {
    flitHead = 1'b0,
    flitBody = 1'b1
  } flitKind;

  typedef enum logic [2:0] {
    idle       = 3'd0,
    grantLocal = 3'd1,
    grantNorth = 3'd2,
    grantEast  = 3'd3,
    grantWest  = 3'd4,
    grantSouth = 3'd5
  } arbState;

  // Sits in the low bits of a head flit payload
  typedef struct packed {
    logic [`COORD_WIDTH-1:0] destX;
    logic [`COORD_WIDTH-1:0] destY;
    logic [`LEN_WIDTH-1:0]   length;
  } headFields;

  typedef struct packed {
    flitKind                   kind;
    logic [`PAYLOAD_WIDTH-1:0] payload;
  } flitT;

  localparam int headWidth = $bits(headFields);

endpackage

//--- design/router_settings.svh
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// Flits per input FIFO, also the credits each output starts with
`define BUFFER_DEPTH 4

// Mesh coordinate width
`define COORD_WIDTH 4

// Packet length in flits, head included
`define LEN_WIDTH 12

// Must hold a headFields overlay
`define PAYLOAD_WIDTH 32

`endif
